// File: design/iq_capture_pkg.sv
// assumes a dma fifo of 8188 usable 64-bit words and a ring of 1024 words of two samples each
`default_nettype none

package iq_capture_pkg;

	localparam int BUF_ADDR_WIDTH = 10;
	localparam int BUF_DEPTH = 2 ** BUF_ADDR_WIDTH;
	localparam int MAX_DMA_SYMBOLS = 8188; // biggest udp payload in 64-bit words

	typedef logic [31:0] iq_sample_t; // i and q, 16 bits each
	typedef logic [63:0] iq_word_t; // two samples, or the tsf header
	typedef logic [63:0] tsf_t;
	typedef logic [BUF_ADDR_WIDTH-1:0] buf_addr_t;
	typedef logic [13:0] sym_count_t;
	typedef logic signed [10:0] rssi_t; // half dB steps
	typedef logic [7:0] gpio_status_t; // lock flag on top of a 7-bit gain
	typedef logic [6:0] gain_t;
	typedef logic [1:0] src_sel_t;
	typedef logic [2:0] trig_sel_t;

	// sample sources
	localparam src_sel_t SRC_RX = 2'd0;
	localparam src_sel_t SRC_TX_MOD = 2'd1;
	localparam src_sel_t SRC_TX_INTF = 2'd2; // code 3 also lands here

	// trigger conditions, also the bit index into the condition vector
	localparam trig_sel_t TRIG_FCS_OK = 3'd0;
	localparam trig_sel_t TRIG_FCS_BAD = 3'd1;
	localparam trig_sel_t TRIG_RSSI_UP = 3'd2;
	localparam trig_sel_t TRIG_RSSI_DOWN = 3'd3;
	localparam trig_sel_t TRIG_AGC_UNLOCK = 3'd4;
	localparam trig_sel_t TRIG_AGC_LOCK = 3'd5;
	localparam trig_sel_t TRIG_TX_RF_START = 3'd6;
	localparam trig_sel_t TRIG_TX_RF_END = 3'd7;

	typedef enum logic [1:0] {
		wait_trigger,
		check_space,
		send_header,
		send_samples
	} capture_state_e;

endpackage

`default_nettype wire

// File: design/trig_stream_if.sv
// one producer only; trigger is a single-cycle pulse and trigger_tsf holds until the next one
`timescale 1ns/1ps
`default_nettype none

interface trig_stream_if;

	iq_capture_pkg::iq_word_t sample; // {iq1, iq0}
	logic sample_strobe;
	logic trigger;
	iq_capture_pkg::tsf_t trigger_tsf;

	modport source (
		output sample,
		output sample_strobe,
		output trigger,
		output trigger_tsf
	);

	modport sink (
		input sample,
		input sample_strobe,
		input trigger,
		input trigger_tsf
	);

endinterface

`default_nettype wire

// File: design/ring_read_if.sv
// read_data lags read_addr by one clock and only updates while read_en is high
`timescale 1ns/1ps
`default_nettype none

interface ring_read_if;

	iq_capture_pkg::buf_addr_t write_addr;
	iq_capture_pkg::buf_addr_t read_addr;
	logic read_en;
	iq_capture_pkg::iq_word_t read_data;

	modport buffer (
		output write_addr,
		output read_data,
		input read_addr,
		input read_en
	);

	modport reader (
		input write_addr,
		input read_data,
		output read_addr,
		output read_en
	);

endinterface

`default_nettype wire

// File: design/iq_trigger_detect.sv
// trigger pulses two clocks after the event and AGC lock gained also needs gain at or above gain_threshold
`timescale 1ns/1ps
`default_nettype none

module iq_trigger_detect (
	input wire clk,
	input wire rstn,
	input wire capture_en,
	input wire iq_capture_pkg::src_sel_t source_select,
	input wire iq_capture_pkg::iq_sample_t rx_iq0,
	input wire iq_capture_pkg::iq_sample_t rx_iq1,
	input wire rx_strobe,
	input wire iq_capture_pkg::iq_sample_t txmod_iq0,
	input wire iq_capture_pkg::iq_sample_t txmod_iq1,
	input wire txmod_strobe,
	input wire iq_capture_pkg::iq_sample_t txintf_iq0,
	input wire iq_capture_pkg::iq_sample_t txintf_iq1,
	input wire txintf_strobe,
	input wire iq_capture_pkg::tsf_t tsf,
	input wire iq_capture_pkg::rssi_t rssi_half_db,
	input wire iq_capture_pkg::gpio_status_t gpio_status,
	input wire fcs_strobe,
	input wire fcs_ok,
	input wire tx_rf_ongoing,
	input wire iq_capture_pkg::trig_sel_t trigger_select,
	input wire iq_capture_pkg::rssi_t rssi_threshold,
	input wire iq_capture_pkg::gain_t gain_threshold,
	trig_stream_if.source stream
);

	iq_capture_pkg::iq_word_t mux_word;
	logic mux_strobe;
	iq_capture_pkg::rssi_t rssi_prev;
	logic lock_prev;
	logic tx_prev;
	logic [7:0] cond; // one registered condition per trigger code
	logic lock_now;
	iq_capture_pkg::gain_t gain_now;

	assign lock_now = gpio_status[7];
	assign gain_now = gpio_status[6:0];

	always_comb begin
		case (source_select)
			iq_capture_pkg::SRC_RX: begin
				mux_word = {rx_iq1, rx_iq0};
				mux_strobe = rx_strobe;
			end
			iq_capture_pkg::SRC_TX_MOD: begin
				mux_word = {txmod_iq1, txmod_iq0};
				mux_strobe = txmod_strobe;
			end
			default: begin
				mux_word = {txintf_iq1, txintf_iq0};
				mux_strobe = txintf_strobe;
			end
		endcase
	end

	// sample word is payload only
	always_ff @(posedge clk) begin
		if (capture_en)
			stream.sample <= mux_word;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			stream.sample_strobe <= 1'b0;
			stream.trigger <= 1'b0;
			rssi_prev <= '0;
			lock_prev <= 1'b0;
			tx_prev <= 1'b0;
			cond <= '0;
		end else if (capture_en) begin
			stream.sample_strobe <= mux_strobe;
			rssi_prev <= rssi_half_db;
			lock_prev <= lock_now;
			tx_prev <= tx_rf_ongoing;

			cond[iq_capture_pkg::TRIG_FCS_OK] <= fcs_strobe && fcs_ok;
			cond[iq_capture_pkg::TRIG_FCS_BAD] <= fcs_strobe && !fcs_ok;
			cond[iq_capture_pkg::TRIG_RSSI_UP] <= (rssi_prev < rssi_threshold) &&
				(rssi_half_db >= rssi_threshold);
			cond[iq_capture_pkg::TRIG_RSSI_DOWN] <= (rssi_prev >= rssi_threshold) &&
				(rssi_half_db < rssi_threshold);
			cond[iq_capture_pkg::TRIG_AGC_UNLOCK] <= lock_prev && !lock_now;
			cond[iq_capture_pkg::TRIG_AGC_LOCK] <= !lock_prev && lock_now &&
				(gain_now >= gain_threshold); // settled at a usable gain
			cond[iq_capture_pkg::TRIG_TX_RF_START] <= tx_rf_ongoing && !tx_prev;
			cond[iq_capture_pkg::TRIG_TX_RF_END] <= !tx_rf_ongoing && tx_prev;

			stream.trigger <= cond[trigger_select]; // second stage of the two-cycle path
		end else begin
			stream.sample_strobe <= 1'b0;
			stream.trigger <= 1'b0;
			cond <= '0;
		end
	end

	// time is locked together with the pulse
	always_ff @(posedge clk) begin
		if (capture_en && cond[trigger_select])
			stream.trigger_tsf <= tsf;
	end

endmodule

`default_nettype wire

// File: design/iq_ring_buffer.sv
// single clock ring with read-before-write on a shared address and no overflow detection
`timescale 1ns/1ps
`default_nettype none

module iq_ring_buffer (
	input wire clk,
	input wire rstn,
	input wire capture_en,
	trig_stream_if.sink stream,
	ring_read_if.buffer rd
);

	iq_capture_pkg::iq_word_t mem [iq_capture_pkg::BUF_DEPTH];
	iq_capture_pkg::buf_addr_t write_ptr;
	logic write_en;

	assign write_en = capture_en && stream.sample_strobe;
	assign rd.write_addr = write_ptr; // next slot to be written

	// wraps at the buffer depth
	always_ff @(posedge clk) begin
		if (!rstn)
			write_ptr <= '0;
		else if (write_en)
			write_ptr <= write_ptr + 1'b1;
	end

	// one write port, one registered read port
	always_ff @(posedge clk) begin
		if (write_en)
			mem[write_ptr] <= stream.sample;
		if (rd.read_en)
			rd.read_data <= mem[rd.read_addr];
	end

endmodule

`default_nettype wire

// File: design/iq_capture_sequencer.sv
// no back-pressure on data_out so a capture only starts when the dma fifo has room for all of it
`timescale 1ns/1ps
`default_nettype none

module iq_capture_sequencer (
	input wire clk,
	input wire rstn,
	input wire capture_en,
	input wire iq_capture_pkg::sym_count_t pre_trigger_len,
	input wire iq_capture_pkg::sym_count_t capture_len,
	input wire iq_capture_pkg::sym_count_t fifo_data_count,
	trig_stream_if.sink stream,
	ring_read_if.reader rd,
	output iq_capture_pkg::iq_word_t data_out,
	output logic data_out_valid
);

	iq_capture_pkg::capture_state_e state;
	iq_capture_pkg::buf_addr_t rd_ptr;
	iq_capture_pkg::sym_count_t sent_count;
	logic out_valid;
	logic space_ok;
	logic sample_step;

	// header plus capture_len samples must fit
	assign space_ok = (15'(fifo_data_count) + 15'(capture_len) + 15'd1) <=
		15'(iq_capture_pkg::MAX_DMA_SYMBOLS);

	assign sample_step = (state == iq_capture_pkg::send_samples) && stream.sample_strobe;

	// look one address ahead so back-to-back strobes read back-to-back words
	assign rd.read_addr = sample_step ? iq_capture_pkg::buf_addr_t'(rd_ptr + 1'b1) : rd_ptr;
	assign rd.read_en = capture_en;

	assign data_out_valid = out_valid && capture_en;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= iq_capture_pkg::wait_trigger;
			out_valid <= 1'b0;
			rd_ptr <= '0;
			sent_count <= '0;
		end else if (!capture_en) begin
			out_valid <= 1'b0; // state holds until re-enabled
		end else begin
			out_valid <= 1'b0;
			case (state)
				iq_capture_pkg::wait_trigger: begin
					sent_count <= '0;
					if (stream.trigger) begin
						rd_ptr <= rd.write_addr - iq_capture_pkg::buf_addr_t'(pre_trigger_len);
						state <= iq_capture_pkg::check_space;
					end
				end
				iq_capture_pkg::check_space: begin
					if (space_ok) begin
						out_valid <= 1'b1; // header goes out next cycle
						state <= iq_capture_pkg::send_header;
					end else begin
						state <= iq_capture_pkg::wait_trigger; // drop silently
					end
				end
				iq_capture_pkg::send_header: begin
					if (capture_len == '0)
						state <= iq_capture_pkg::wait_trigger;
					else
						state <= iq_capture_pkg::send_samples;
				end
				iq_capture_pkg::send_samples: begin
					if (stream.sample_strobe) begin
						out_valid <= 1'b1;
						rd_ptr <= rd_ptr + 1'b1;
						sent_count <= sent_count + 1'b1;
						if (sent_count == iq_capture_pkg::sym_count_t'(capture_len - 1'b1))
							state <= iq_capture_pkg::wait_trigger;
					end
				end
				default: state <= iq_capture_pkg::wait_trigger;
			endcase
		end
	end

	// output word, header is parked here at the trigger
	always_ff @(posedge clk) begin
		if (capture_en) begin
			if (state == iq_capture_pkg::wait_trigger && stream.trigger)
				data_out <= iq_capture_pkg::iq_word_t'(stream.trigger_tsf);
			else if (sample_step)
				data_out <= rd.read_data;
		end
	end

endmodule

`default_nettype wire

// File: design/iq_capture_top.sv
// all inputs share clk and reach the header two clocks after the trigger pulse
`timescale 1ns/1ps
`default_nettype none

module iq_capture_top (
	input wire clk,
	input wire rstn,
	input wire capture_en,
	input wire iq_capture_pkg::src_sel_t source_select,
	input wire iq_capture_pkg::iq_sample_t rx_iq0,
	input wire iq_capture_pkg::iq_sample_t rx_iq1,
	input wire rx_strobe,
	input wire iq_capture_pkg::iq_sample_t txmod_iq0,
	input wire iq_capture_pkg::iq_sample_t txmod_iq1,
	input wire txmod_strobe,
	input wire iq_capture_pkg::iq_sample_t txintf_iq0,
	input wire iq_capture_pkg::iq_sample_t txintf_iq1,
	input wire txintf_strobe,
	input wire iq_capture_pkg::tsf_t tsf,
	input wire iq_capture_pkg::rssi_t rssi_half_db,
	input wire iq_capture_pkg::gpio_status_t gpio_status,
	input wire fcs_strobe,
	input wire fcs_ok,
	input wire tx_rf_ongoing,
	input wire iq_capture_pkg::trig_sel_t trigger_select,
	input wire iq_capture_pkg::rssi_t rssi_threshold,
	input wire iq_capture_pkg::gain_t gain_threshold,
	input wire iq_capture_pkg::sym_count_t pre_trigger_len,
	input wire iq_capture_pkg::sym_count_t capture_len,
	input wire iq_capture_pkg::sym_count_t fifo_data_count,
	output iq_capture_pkg::iq_word_t data_out,
	output logic data_out_valid
);

	trig_stream_if stream_if ();
	ring_read_if rd_if ();

	iq_trigger_detect iq_trigger_detect_i (
		.clk(clk),
		.rstn(rstn),
		.capture_en(capture_en),
		.source_select(source_select),
		.rx_iq0(rx_iq0),
		.rx_iq1(rx_iq1),
		.rx_strobe(rx_strobe),
		.txmod_iq0(txmod_iq0),
		.txmod_iq1(txmod_iq1),
		.txmod_strobe(txmod_strobe),
		.txintf_iq0(txintf_iq0),
		.txintf_iq1(txintf_iq1),
		.txintf_strobe(txintf_strobe),
		.tsf(tsf),
		.rssi_half_db(rssi_half_db),
		.gpio_status(gpio_status),
		.fcs_strobe(fcs_strobe),
		.fcs_ok(fcs_ok),
		.tx_rf_ongoing(tx_rf_ongoing),
		.trigger_select(trigger_select),
		.rssi_threshold(rssi_threshold),
		.gain_threshold(gain_threshold),
		.stream(stream_if.source)
	);

	iq_ring_buffer iq_ring_buffer_i (
		.clk(clk),
		.rstn(rstn),
		.capture_en(capture_en),
		.stream(stream_if.sink),
		.rd(rd_if.buffer)
	);

	iq_capture_sequencer iq_capture_sequencer_i (
		.clk(clk),
		.rstn(rstn),
		.capture_en(capture_en),
		.pre_trigger_len(pre_trigger_len),
		.capture_len(capture_len),
		.fifo_data_count(fifo_data_count),
		.stream(stream_if.sink),
		.rd(rd_if.reader),
		.data_out(data_out),
		.data_out_valid(data_out_valid)
	);

endmodule

`default_nettype wire

// File: tests/iq_capture_properties.sv
// port level rules only; an input event is an fcs strobe or any change of rssi, gain status or tx level
`timescale 1ns/1ps
`default_nettype none

module iq_capture_properties (
	input wire clk,
	input wire rstn,
	input wire capture_en,
	input wire fcs_strobe,
	input wire iq_capture_pkg::rssi_t rssi_half_db,
	input wire iq_capture_pkg::gpio_status_t gpio_status,
	input wire tx_rf_ongoing,
	input wire data_out_valid
);

	iq_capture_pkg::rssi_t rssi_q;
	iq_capture_pkg::gpio_status_t status_q;
	logic tx_q;
	logic event_now;
	logic event_seen; // sticky from the first enabled event

	assign event_now = fcs_strobe || (rssi_half_db != rssi_q) ||
		(gpio_status != status_q) || (tx_rf_ongoing != tx_q);

	always_ff @(posedge clk) begin
		rssi_q <= rssi_half_db;
		status_q <= gpio_status;
		tx_q <= tx_rf_ongoing;
	end

	// events while disabled never reach the trigger stage
	always_ff @(posedge clk) begin
		if (!rstn)
			event_seen <= 1'b0;
		else if (event_now && capture_en)
			event_seen <= 1'b1;
	end

	// no output while held in reset or disabled
	quiet_when_off: assert property (@(posedge clk)
		(!rstn || !capture_en) |-> !data_out_valid)
		else $error("data_out_valid high during reset or with capture disabled");

	// header needs at least two clocks from the event
	no_early_output: assert property (@(posedge clk) disable iff (!rstn)
		$rose(data_out_valid) |-> $past(event_seen, 2))
		else $error("data_out_valid rose without an input event two cycles earlier");

endmodule

`default_nettype wire

// File: tests/iq_capture_tb.sv
// drives only the receive source with a counter in both halves; tsf counts up one per clock
`timescale 1ns/1ps
`default_nettype none

module iq_capture_tb;

	localparam int PRE_LEN = 8;
	localparam int CAP_LEN = 16;
	localparam int WAIT_LIMIT = 400; // clocks per capture wait

	logic clk;
	logic rstn;
	logic capture_en;
	iq_capture_pkg::src_sel_t source_select;
	iq_capture_pkg::iq_sample_t rx_iq0;
	iq_capture_pkg::iq_sample_t rx_iq1;
	logic rx_strobe;
	iq_capture_pkg::iq_sample_t txmod_iq0;
	iq_capture_pkg::iq_sample_t txmod_iq1;
	logic txmod_strobe;
	iq_capture_pkg::iq_sample_t txintf_iq0;
	iq_capture_pkg::iq_sample_t txintf_iq1;
	logic txintf_strobe;
	iq_capture_pkg::tsf_t tsf;
	iq_capture_pkg::rssi_t rssi_half_db;
	iq_capture_pkg::gpio_status_t gpio_status;
	logic fcs_strobe;
	logic fcs_ok;
	logic tx_rf_ongoing;
	iq_capture_pkg::trig_sel_t trigger_select;
	iq_capture_pkg::rssi_t rssi_threshold;
	iq_capture_pkg::gain_t gain_threshold;
	iq_capture_pkg::sym_count_t pre_trigger_len;
	iq_capture_pkg::sym_count_t capture_len;
	iq_capture_pkg::sym_count_t fifo_data_count;
	iq_capture_pkg::iq_word_t data_out;
	logic data_out_valid;

	int seed;
	logic [31:0] cnt; // next value on the receive pair
	logic use_gaps;
	int checks;
	int errors;
	int timeouts;
	iq_capture_pkg::iq_word_t words_q[$];
	iq_capture_pkg::tsf_t tsf_q[$]; // tsf seen with each word

	iq_capture_top iq_capture_top_i (.*);

	bind iq_capture_top iq_capture_properties iq_capture_properties_i (
		.clk(clk),
		.rstn(rstn),
		.capture_en(capture_en),
		.fcs_strobe(fcs_strobe),
		.rssi_half_db(rssi_half_db),
		.gpio_status(gpio_status),
		.tx_rf_ongoing(tx_rf_ongoing),
		.data_out_valid(data_out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(negedge clk) begin
		if (data_out_valid) begin
			words_q.push_back(data_out);
			tsf_q.push_back(tsf);
		end
	end

	task automatic tick();
		@(posedge clk);
		#2;
		tsf = tsf + 64'd1;
		fcs_strobe = 1'b0;
		rx_strobe = !use_gaps || (($random(seed) & 3) != 0);
		rx_iq0 = cnt;
		rx_iq1 = cnt;
		if (rx_strobe)
			cnt = cnt + 32'd1;
	endtask

	task automatic run_idle(input int n);
		repeat (n) tick();
	endtask

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("FAILED at %0t ns: %s", $time, msg);
		end
	endtask

	// caller applies the event right after this returns
	task automatic arm_event(output logic [31:0] trig_cnt, output iq_capture_pkg::tsf_t trig_tsf);
		words_q.delete();
		tsf_q.delete();
		tick();
		trig_cnt = cnt;
		trig_tsf = tsf;
	endtask

	task automatic expect_quiet(input int n, input string label);
		run_idle(n);
		check(words_q.size() == 0, $sformatf("%s gave %0d words", label, words_q.size()));
	endtask

	task automatic check_capture(input logic [31:0] trig_cnt, input iq_capture_pkg::tsf_t trig_tsf,
		input string label);
		int waited;
		int i;
		int diff;
		logic [31:0] first;
		iq_capture_pkg::iq_word_t w;
		waited = 0;
		while (words_q.size() < CAP_LEN + 1 && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (words_q.size() < CAP_LEN + 1) begin
			timeouts++;
			$display("%s: timed out waiting for the capture words", label);
		end else begin
			run_idle(30); // room for any stray word
			check(words_q.size() == CAP_LEN + 1,
				$sformatf("%s gave %0d words, expected %0d", label, words_q.size(), CAP_LEN + 1));
			check(words_q[0] >= trig_tsf && words_q[0] <= tsf_q[0],
				$sformatf("%s header %h outside %h..%h", label, words_q[0], trig_tsf, tsf_q[0]));
			first = words_q[1][31:0];
			diff = int'(first - (trig_cnt - 32'(PRE_LEN)));
			check(diff >= -2 && diff <= 2,
				$sformatf("%s first sample %h, trigger count %h", label, first, trig_cnt));
			for (i = 1; i <= CAP_LEN; i++) begin
				w = words_q[i];
				check(w[63:32] == w[31:0] && w[31:0] == first + 32'(i - 1),
					$sformatf("%s word %0d is %h, expected %h twice", label, i, w,
					first + 32'(i - 1)));
			end
		end
	endtask

	initial begin
		logic [31:0] c0;
		iq_capture_pkg::tsf_t t0;
		seed = 32'hd0baf78d;
		checks = 0;
		errors = 0;
		timeouts = 0;
		cnt = 32'd0;
		use_gaps = 1'b0;
		rstn = 1'b0;
		capture_en = 1'b0;
		source_select = iq_capture_pkg::SRC_RX;
		rx_iq0 = '0;
		rx_iq1 = '0;
		rx_strobe = 1'b0;
		txmod_iq0 = '0;
		txmod_iq1 = '0;
		txmod_strobe = 1'b0;
		txintf_iq0 = '0;
		txintf_iq1 = '0;
		txintf_strobe = 1'b0;
		tsf = 64'h0000_0001_0000_0000;
		rssi_half_db = -11'sd200;
		gpio_status = 8'h9e; // locked at gain 30
		fcs_strobe = 1'b0;
		fcs_ok = 1'b0;
		tx_rf_ongoing = 1'b0;
		trigger_select = iq_capture_pkg::TRIG_FCS_OK;
		rssi_threshold = -11'sd120;
		gain_threshold = 7'd20;
		pre_trigger_len = iq_capture_pkg::sym_count_t'(PRE_LEN);
		capture_len = iq_capture_pkg::sym_count_t'(CAP_LEN);
		fifo_data_count = '0;
		run_idle(8);
		rstn = 1'b1;

		// every event kind while disabled
		arm_event(c0, t0);
		fcs_strobe = 1'b1;
		fcs_ok = 1'b1;
		tick();
		rssi_half_db = -11'sd100;
		tick();
		gpio_status = 8'h1e;
		expect_quiet(40, "disabled capture");
		rssi_half_db = -11'sd200;
		gpio_status = 8'h9e;
		tick();
		capture_en = 1'b1;
		run_idle(40); // fill the ring past the pre-trigger span

		arm_event(c0, t0);
		fcs_strobe = 1'b1;
		fcs_ok = 1'b1;
		check_capture(c0, t0, "fcs ok");

		trigger_select = iq_capture_pkg::TRIG_FCS_BAD;
		use_gaps = 1'b1;
		arm_event(c0, t0);
		fcs_strobe = 1'b1;
		fcs_ok = 1'b1;
		expect_quiet(40, "good fcs with bad fcs selected");
		arm_event(c0, t0);
		fcs_strobe = 1'b1;
		fcs_ok = 1'b0;
		check_capture(c0, t0, "fcs bad");

		trigger_select = iq_capture_pkg::TRIG_RSSI_UP;
		arm_event(c0, t0);
		rssi_half_db = -11'sd100;
		check_capture(c0, t0, "rssi up");
		arm_event(c0, t0);
		rssi_half_db = -11'sd90;
		expect_quiet(40, "rssi held above threshold");
		rssi_half_db = -11'sd200;

		trigger_select = iq_capture_pkg::TRIG_AGC_UNLOCK;
		arm_event(c0, t0);
		gpio_status = 8'h1e;
		check_capture(c0, t0, "agc unlock");
		arm_event(c0, t0);
		gpio_status = 8'h9e;
		expect_quiet(30, "agc relock with unlock selected");

		// free space one short, then just enough
		trigger_select = iq_capture_pkg::TRIG_FCS_OK;
		use_gaps = 1'b0;
		fifo_data_count = iq_capture_pkg::sym_count_t'(iq_capture_pkg::MAX_DMA_SYMBOLS - CAP_LEN);
		arm_event(c0, t0);
		fcs_strobe = 1'b1;
		fcs_ok = 1'b1;
		expect_quiet(40, "full dma fifo");
		fifo_data_count = iq_capture_pkg::sym_count_t'(iq_capture_pkg::MAX_DMA_SYMBOLS - CAP_LEN - 1);
		arm_event(c0, t0);
		fcs_strobe = 1'b1;
		fcs_ok = 1'b1;
		check_capture(c0, t0, "dma fifo just fits");

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
design/iq_capture_pkg.sv
design/trig_stream_if.sv
design/ring_read_if.sv
design/iq_trigger_detect.sv
design/iq_ring_buffer.sv
design/iq_capture_sequencer.sv
design/iq_capture_top.sv
tests/iq_capture_properties.sv
tests/iq_capture_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module iq_capture_tb -f filelist.f -o iq_capture_sim &&
result="$(./obj_dir/iq_capture_sim)"
echo "$result"
echo "$result" | grep -q "Testbench passed" && echo "simulation run passed" || {
	echo "simulation run failed"
	exit 1
}
